/* switch_alloc.f */
+incdir+tb
design/noc_cfg_pkg.sv
design/alloc_pkg.sv
design/rr_arbiter.sv
design/config_delay.sv
design/slot_allocator.sv
design/switch_alloc.sv
tb/tb_switch_alloc.sv

/* Makefile */
TOP := tb_switch_alloc

.PHONY: help test clean

help:
	@echo "make test   build the testbench with Verilator and run it"
	@echo "make clean  remove the build directory"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
	  --Mdir build -f switch_alloc.f
	@out=$$(./build/V$(TOP)); echo "$$out"; \
	  echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf build

/* tb/tb_checks.svh */
/*
  Typed compare tasks, bounded waits and error counters
  for the switch allocator testbench
*/

int value_errs   = 0;
int timeout_errs = 0;

task automatic check_grant(input grant_vec_t act, input grant_vec_t exp);
  if (act !== exp) begin
    value_errs++;
    $display("ERR grant_valid got %h expected %h at %0t", act, exp, $time);
  end
endtask

task automatic check_switch(input int row, input grant_vec_t act, input grant_vec_t exp);
  if (act !== exp) begin
    value_errs++;
    $display("ERR grant_switch[%0d] got %h expected %h at %0t", row, act, exp, $time);
  end
endtask

task automatic check_gap(input int act, input int exp);
  if (act != exp) begin
    value_errs++;
    $display("ERR grant spacing got %h expected %h cycles at %0t", act, exp, $time);
  end
endtask

task automatic note_timeout(input string what);
  timeout_errs++;
  $display("timeout: no %s within %0d cycles at %0t", what, WAIT_LIMIT, $time);
endtask

// Step falling edges until any grant pulse shows up or the limit runs out
task automatic wait_grant(input int limit, output int cycles, output bit seen);
  cycles = 0;
  seen   = 1'b0;
  while (!seen && cycles < limit) begin
    @(negedge clk);
    cycles++;
    seen = (grant_valid != '0);
  end
endtask

// All slots are over once outputs stay quiet for longer than the flight time
task automatic wait_quiet();
  int  quiet;
  int  cycles;
  int  r;
  bit  busy;
  quiet  = 0;
  cycles = 0;
  while (quiet <= TOF && cycles < WAIT_LIMIT) begin
    @(negedge clk);
    cycles++;
    busy = (grant_valid != '0);
    for (r = 0; r < PORTS; r++) begin
      busy = busy | (grant_switch[r] != '0);
    end
    quiet = busy ? 0 : quiet + 1;
  end
  if (quiet <= TOF) begin
    timeout_errs++;
    $display("timeout: outputs never went quiet at %0t", $time);
  end
endtask

/* tb/tb_switch_alloc.sv */
/*
  Directed testbench for the switch allocator that covers single grants,
  arbitration order, counted requests and the delayed crossbar matrix
*/
`default_nettype none

module tb_switch_alloc
  import noc_cfg_pkg::*;
  import alloc_pkg::*;
();

  localparam int PORTS      = DEF_PORTS;
  localparam int SLOT_SIZE  = DEF_SLOT_SIZE;
  localparam int TOF        = DEF_TOF;
  localparam int IDX_BITS   = $clog2(DEF_PORTS);
  localparam int WAIT_LIMIT = 4 * DEF_SLOT_SIZE + 20;

  logic             clk;
  logic             rst;
  logic [PORTS-1:0] req_valid;
  port_idx_t        req_port     [PORTS];
  grant_vec_t       grant_valid;
  grant_vec_t       grant_switch [PORTS];
  logic [31:0]      lfsr = 32'he922_6f77;

  `include "tb_checks.svh"

  switch_alloc #(
    .PORTS      (DEF_PORTS),
    .SLOT_SIZE  (DEF_SLOT_SIZE),
    .FIFO_DEPTH (DEF_FIFO_DEPTH),
    .TOF        (DEF_TOF)
  ) DUT (
    .clk          (clk),
    .rst          (rst),
    .req_valid    (req_valid),
    .req_port     (req_port),
    .grant_valid  (grant_valid),
    .grant_switch (grant_switch)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output int val);
    val = 0;
    repeat (n) begin
      lfsr = lfsr_next(lfsr);
      val  = (val << 1) | int'(lfsr[0]);
    end
  endtask

  task automatic set_req(input int src, input int dst);
    req_valid[src] = 1'b1;
    req_port[src]  = port_idx_t'(dst);
  endtask

  task automatic release_reqs();
    @(negedge clk);
    req_valid = '0;
  endtask

  task automatic expect_grant(input grant_vec_t exp, output int cycles);
    bit seen;
    wait_grant(WAIT_LIMIT, cycles, seen);
    if (seen) begin
      check_grant(grant_valid, exp);
    end else begin
      note_timeout("grant");
    end
  endtask

  task automatic test_idle();
    int k;
    int r;
    for (k = 0; k < 3 * SLOT_SIZE; k++) begin
      @(negedge clk);
      check_grant(grant_valid, '0);
      for (r = 0; r < PORTS; r++) begin
        check_switch(r, grant_switch[r], '0);
      end
    end
  endtask

  // Grant comes one cycle after the counter sees the pulse
  // Row 2 follows TOF cycles after the grant
  task automatic test_single();
    int         k;
    grant_vec_t exp;
    set_req(1, 2);
    release_reqs();
    check_grant(grant_valid, '0);
    @(negedge clk);
    check_grant(grant_valid, grant_vec_t'(1) << 1);
    for (k = 1; k <= TOF + SLOT_SIZE; k++) begin
      @(negedge clk);
      check_grant(grant_valid, '0);
      exp = (k >= TOF && k < TOF + SLOT_SIZE) ? grant_vec_t'(1) << 1 : '0;
      check_switch(2, grant_switch[2], exp);
    end
    wait_quiet();
  endtask

  task automatic test_two_inputs();
    int cycles;
    set_req(0, 1);
    set_req(3, 1);
    release_reqs();
    expect_grant(grant_vec_t'(1), cycles);
    check_gap(cycles, 1);
    expect_grant(grant_vec_t'(1) << 3, cycles);
    check_gap(cycles, SLOT_SIZE);
    wait_quiet();
  endtask

  // Second pulse lands on the first grant
  // Third pulse waits in the counter
  task automatic test_counted();
    int cycles;
    bit seen;
    set_req(2, 0);
    @(negedge clk);
    @(negedge clk);
    check_grant(grant_valid, grant_vec_t'(1) << 2);
    release_reqs();
    expect_grant(grant_vec_t'(1) << 2, cycles);
    check_gap(cycles, SLOT_SIZE - 1);
    expect_grant(grant_vec_t'(1) << 2, cycles);
    check_gap(cycles, SLOT_SIZE);
    wait_grant(3 * SLOT_SIZE, cycles, seen);
    if (seen) begin
      value_errs++;
      $display("input 2 got a fourth grant after only three requests at %0t", $time);
    end
    wait_quiet();
  endtask

  task automatic test_permutation();
    int         perm [PORTS];
    int         k;
    int         j;
    int         t;
    int         cycles;
    grant_vec_t exp  [PORTS];
    for (k = 0; k < PORTS; k++) begin
      perm[k] = k;
    end
    // Shuffle of the outputs
    for (k = PORTS - 1; k > 0; k--) begin
      take_bits(IDX_BITS, j);
      j       = j % (k + 1);
      t       = perm[k];
      perm[k] = perm[j];
      perm[j] = t;
    end
    for (k = 0; k < PORTS; k++) begin
      set_req(k, perm[k]);
      exp[perm[k]] = grant_vec_t'(1) << k;
    end
    release_reqs();
    expect_grant(grant_vec_t'((1 << PORTS) - 1), cycles);
    check_gap(cycles, 1);
    repeat (TOF) @(negedge clk);
    for (k = 0; k < PORTS; k++) begin
      check_switch(k, grant_switch[k], exp[k]);
    end
    wait_quiet();
  endtask

  initial begin
    rst       = 1'b1;
    req_valid = '0;
    for (int i = 0; i < PORTS; i++) begin
      req_port[i] = '0;
    end
    repeat (5) @(negedge clk);
    rst = 1'b0;
    test_idle();
    test_single();
    test_two_inputs();
    test_counted();
    test_permutation();
    $display("errors: %0d value, %0d timeout", value_errs, timeout_errs);
    if (value_errs + timeout_errs == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* design/switch_alloc.sv */
/*
  Switch allocator top, joins the slot allocator to the crossbar
  configuration delay
*/
`default_nettype none

module switch_alloc
  import noc_cfg_pkg::*;
  import alloc_pkg::*;
#(
  parameter int PORTS      = DEF_PORTS,
  parameter int SLOT_SIZE  = DEF_SLOT_SIZE,
  parameter int FIFO_DEPTH = DEF_FIFO_DEPTH,
  parameter int TOF        = DEF_TOF
) (
  input  logic             clk,
  input  logic             rst,
  input  logic [PORTS-1:0] req_valid,
  input  port_idx_t        req_port     [PORTS],
  output grant_vec_t       grant_valid,
  output grant_vec_t       grant_switch [PORTS]
);

  grant_vec_t config_matrix [PORTS];

  if (PORTS < 1 || PORTS > MAX_PORTS) begin : g_bad_ports
    $error("PORTS must lie between 1 and %0d", MAX_PORTS);
  end

  slot_allocator #(
    .PORTS      (PORTS),
    .SLOT_SIZE  (SLOT_SIZE),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_alloc (
    .clk           (clk),
    .rst           (rst),
    .req_valid     (req_valid),
    .req_port      (req_port),
    .grant_valid   (grant_valid),
    .config_matrix (config_matrix)
  );

  // Matrix reaches the crossbar TOF cycles after the grant
  config_delay #(
    .DEPTH (TOF),
    .PORTS (PORTS)
  ) u_delay (
    .clk  (clk),
    .rst  (rst),
    .din  (config_matrix),
    .dout (grant_switch)
  );

endmodule

`default_nettype wire

/* design/slot_allocator.sv */
/*
  Slot allocator: pending-message counters per input/output pair, one
  round-robin arbiter per output, fixed-length slot timers, registered grants
*/
`default_nettype none

module slot_allocator
  import noc_cfg_pkg::*;
  import alloc_pkg::*;
#(
  parameter int PORTS      = DEF_PORTS,
  parameter int SLOT_SIZE  = DEF_SLOT_SIZE,
  parameter int FIFO_DEPTH = DEF_FIFO_DEPTH
) (
  input  logic             clk,
  input  logic             rst,
  input  logic [PORTS-1:0] req_valid,
  input  port_idx_t        req_port [PORTS],
  output grant_vec_t       grant_valid,
  output grant_vec_t       config_matrix [PORTS]
);

  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);
  localparam int TMR_W = $clog2(SLOT_SIZE + 1);

  // Pending messages, indexed [input][output]
  logic [CNT_W-1:0] cnt     [PORTS][PORTS];
  logic [PORTS-1:0] req_hit [PORTS];  // [input] output named by this cycle's pulse
  logic [PORTS-1:0] elig    [PORTS];  // [input] outputs usable right now
  logic [PORTS-1:0] offer   [PORTS];  // [input] the one output it bids for
  logic [PORTS-1:0] arb_req [PORTS];  // [output] bidding inputs
  logic [PORTS-1:0] arb_gnt [PORTS];  // [output] winning input
  logic [PORTS-1:0] gnt_in  [PORTS];  // [input] granted output
  logic [PORTS-1:0] grant_any;

  // Remaining slot cycles per output, zero means expired
  logic [TMR_W-1:0] timer [PORTS];
  logic [PORTS-1:0] out_busy;
  logic [PORTS-1:0] in_busy;

  // Busy drops in the last slot cycle so the next slot starts back to back
  always_comb begin
    for (int o = 0; o < PORTS; o++) begin
      out_busy[o] = timer[o] > TMR_W'(1);
    end
    for (int i = 0; i < PORTS; i++) begin
      in_busy[i] = 1'b0;
      for (int o = 0; o < PORTS; o++) begin
        in_busy[i] = in_busy[i] | (config_matrix[o][i] & out_busy[o]);
      end
    end
  end

  // Each input bids only for its lowest eligible output,
  // so two arbiters never pick the same input in one cycle
  always_comb begin
    for (int i = 0; i < PORTS; i++) begin
      for (int o = 0; o < PORTS; o++) begin
        req_hit[i][o] = req_valid[i] && (req_port[i] == port_idx_t'(o));
        elig[i][o]    = (cnt[i][o] != '0) && !out_busy[o] && !in_busy[i];
      end
      offer[i] = elig[i] & (~elig[i] + PORTS'(1));
    end
    for (int o = 0; o < PORTS; o++) begin
      for (int i = 0; i < PORTS; i++) begin
        arb_req[o][i] = offer[i][o];
      end
    end
  end

  for (genvar o = 0; o < PORTS; o++) begin : g_arb
    rr_arbiter #(
      .N (PORTS)
    ) u_arb (
      .clk (clk),
      .rst (rst),
      .req (arb_req[o]),
      .gnt (arb_gnt[o])
    );
  end

  // Per-input view of the grants
  always_comb begin
    for (int i = 0; i < PORTS; i++) begin
      for (int o = 0; o < PORTS; o++) begin
        gnt_in[i][o] = arb_gnt[o][i];
      end
      grant_any[i] = |gnt_in[i];
    end
  end

  // A pulse and a grant on the same pair cancel out
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < PORTS; i++) begin
        for (int o = 0; o < PORTS; o++) begin
          cnt[i][o] <= '0;
        end
      end
    end else begin
      for (int i = 0; i < PORTS; i++) begin
        for (int o = 0; o < PORTS; o++) begin
          if (req_hit[i][o] && !gnt_in[i][o]) begin
            if (cnt[i][o] < CNT_W'(FIFO_DEPTH)) begin
              cnt[i][o] <= cnt[i][o] + 1'b1;
            end
          end else if (gnt_in[i][o] && !req_hit[i][o]) begin
            cnt[i][o] <= cnt[i][o] - 1'b1;
          end
        end
      end
    end
  end

  // Slot timers and held switch rows, grant pulses
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int o = 0; o < PORTS; o++) begin
        timer[o]         <= '0;
        config_matrix[o] <= '0;
      end
      grant_valid <= '0;
    end else begin
      for (int o = 0; o < PORTS; o++) begin
        if (arb_gnt[o] != '0) begin
          timer[o]         <= TMR_W'(SLOT_SIZE);
          config_matrix[o] <= grant_vec_t'(arb_gnt[o]);
        end else if (timer[o] != '0) begin
          timer[o] <= timer[o] - 1'b1;
          if (timer[o] == TMR_W'(1)) begin
            config_matrix[o] <= '0;
          end
        end
      end
      grant_valid <= grant_vec_t'(grant_any);
    end
  end

  for (genvar i = 0; i < PORTS; i++) begin : g_chk_in
    a_one_output: assert property (@(posedge clk) disable iff (rst)
      $onehot0(gnt_in[i]))
      else $error("input %0d granted by more than one output", i);

    for (genvar o = 0; o < PORTS; o++) begin : g_chk_pair
      // A pulse into a full counter means a lost message
      a_no_overflow: assert property (@(posedge clk) disable iff (rst)
        !(req_hit[i][o] && !gnt_in[i][o] && (cnt[i][o] == CNT_W'(FIFO_DEPTH))))
        else $error("counter overflow, input %0d output %0d", i, o);
    end
  end

  for (genvar o = 0; o < PORTS; o++) begin : g_chk_row
    a_row_onehot: assert property (@(posedge clk) disable iff (rst)
      $onehot0(config_matrix[o]))
      else $error("switch row %0d connects several inputs", o);
  end

endmodule

`default_nettype wire

/* design/config_delay.sv */
/*
  Crossbar configuration delay, a pipeline of whole switch matrices
  matching the time of flight to the switch
*/
`default_nettype none

module config_delay
  import noc_cfg_pkg::*;
  import alloc_pkg::*;
#(
  parameter int DEPTH = DEF_TOF,
  parameter int PORTS = DEF_PORTS
) (
  input  logic       clk,
  input  logic       rst,
  input  grant_vec_t din  [PORTS],
  output grant_vec_t dout [PORTS]
);

  if (DEPTH == 0) begin : g_wire
    assign dout = din;
  end else begin : g_pipe
    grant_vec_t stage [DEPTH][PORTS];

    always_ff @(posedge clk) begin
      if (rst) begin
        for (int s = 0; s < DEPTH; s++) begin
          for (int p = 0; p < PORTS; p++) begin
            stage[s][p] <= '0;
          end
        end
      end else begin
        stage[0] <= din;
        for (int s = 1; s < DEPTH; s++) begin
          stage[s] <= stage[s-1];
        end
      end
    end

    assign dout = stage[DEPTH-1];
  end

endmodule

`default_nettype wire

/* design/rr_arbiter.sv */
/*
  Round-robin arbiter, combinational one-hot grant with a registered
  priority pointer that moves past each winner
*/
`default_nettype none

module rr_arbiter #(
  parameter int N = 2
) (
  input  logic         clk,
  input  logic         rst,
  input  logic [N-1:0] req,
  output logic [N-1:0] gnt
);

  localparam int PTR_W = (N > 1) ? $clog2(N) : 1;

  logic [PTR_W-1:0] ptr;
  logic [PTR_W-1:0] next_ptr;
  logic             found;

  // Scan from the pointer upwards, wrapping at N
  always_comb begin
    int idx;
    gnt      = '0;
    next_ptr = ptr;
    found    = 1'b0;
    for (int k = 0; k < N; k++) begin
      idx = int'(ptr) + k;
      if (idx >= N) begin
        idx = idx - N;
      end
      if (!found && req[idx]) begin
        found    = 1'b1;
        gnt[idx] = 1'b1;
        next_ptr = (idx == N - 1) ? '0 : PTR_W'(idx + 1);
      end
    end
  end

  // Pointer only moves when someone wins
  always_ff @(posedge clk) begin
    if (rst) begin
      ptr <= '0;
    end else if (found) begin
      ptr <= next_ptr;
    end
  end

  a_gnt_legal: assert property (@(posedge clk) disable iff (rst)
    $onehot0(gnt) && ((gnt & ~req) == '0))
    else $error("arbiter grant not one-hot or not requested");

endmodule

`default_nettype wire

/* design/alloc_pkg.sv */
/*
  Allocator encodings: binary output port numbers on the request side,
  one bit per port on the grant side and in the switch matrix
*/
`default_nettype none

package alloc_pkg;

  import noc_cfg_pkg::*;

  localparam int PORT_IDX_W = $clog2(MAX_PORTS);

  // Destination output of a request, binary
  typedef logic [PORT_IDX_W-1:0] port_idx_t;

  // One bit per port
  // Grant pulses use it per input, the switch matrix per output row
  // Bits at and above the configured port count stay zero
  typedef logic [MAX_PORTS-1:0] grant_vec_t;

endpackage

`default_nettype wire

/* design/noc_cfg_pkg.sv */
/*
  Router configuration: network size limits and the default values
  for the allocator's top-level parameters
*/
`default_nettype none

package noc_cfg_pkg;

  // Largest router supported, fixes the width of port indices
  localparam int MAX_PORTS = 8;

  // Defaults for the switch allocator
  localparam int DEF_PORTS = 4;

  // Cycles that a granted input/output pair keeps the crossbar
  localparam int DEF_SLOT_SIZE = 8;

  // Messages one input FIFO can hold
  localparam int DEF_FIFO_DEPTH = 8;

  // Time of flight from allocator to crossbar, in cycles
  localparam int DEF_TOF = 2;

endpackage

`default_nettype wire
